// ==== compile.f ====
hisPkg.sv
hisDistributor.sv
hisBuilder.sv
peakDetecter.sv
hisTop.sv
hisClkGen.sv
hisTb_chk.sv
hisTb.sv

// ==== hisBuilder.sv ====
`timescale 1ns/1ps

module hisBuilder (
    input  logic                          clk,
    input  logic                          reset,
    input  hisPkg::binUpdate_t            binUpdate,
    input  logic                          readEn,
    input  logic [hisPkg::BIN_BITS-1:0]   readBin,
    output logic [hisPkg::COUNT_BITS-1:0] count
);

    // one counter per bin
    logic [hisPkg::COUNT_BITS-1:0] mem [hisPkg::BIN_NUM];

    // reset walk over all bins
    logic                        clearing;
    logic [hisPkg::BIN_BITS-1:0] clearPtr;

    // read stage of the update pipeline
    logic                          rdValid;
    logic [hisPkg::BIN_BITS-1:0]   rdBin;
    logic [hisPkg::COUNT_BITS-1:0] rdCount;

    // write stage value, saturated
    logic [hisPkg::COUNT_BITS-1:0] incCount;

    // forward the write in flight when the same bin comes right behind it
    logic                          fwdHit;
    logic [hisPkg::COUNT_BITS-1:0] rdSource;

    assign incCount = (rdCount == '1) ? rdCount : rdCount + 1'b1;

    assign fwdHit = rdValid && (rdBin == binUpdate.bin);
    assign rdSource = fwdHit ? incCount : mem[binUpdate.bin];

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing <= 1'b1;
            clearPtr <= '0;
            rdValid <= 1'b0;
        end else begin
            if (clearing) begin
                clearPtr <= clearPtr + 1'b1;
                // last bin zeroed on this edge
                if (clearPtr == '1) begin
                    clearing <= 1'b0;
                end
            end
            rdValid <= binUpdate.valid;
        end
    end

    // read stage payload
    always_ff @(posedge clk) begin
        if (binUpdate.valid) begin
            rdBin <= binUpdate.bin;
            rdCount <= rdSource;
        end
    end

    // single write port
    // reset walk first, then read-and-clear, then the hit update
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clearPtr] <= '0;
        end else if (readEn) begin
            mem[readBin] <= '0;
        end else if (rdValid) begin
            mem[rdBin] <= incCount;
        end
    end

    // read port, count valid the cycle after readEn
    always_ff @(posedge clk) begin
        if (readEn) begin
            count <= mem[readBin];
        end
    end

endmodule

// ==== hisClkGen.sv ====
`timescale 1ns/1ps

module hisClkGen #(
    parameter int HALF_PERIOD = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    // free running clock, 8 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held over the first cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== hisDistributor.sv ====
`timescale 1ns/1ps

module hisDistributor #(
    parameter int PIXEL_NUM = hisPkg::PIXEL_NUM_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,
    input  hisPkg::hisSample_t sample,
    input  logic               sampleValid,
    output logic               sampleReady,
    input  logic               busy,
    output hisPkg::binUpdate_t binUpdate [PIXEL_NUM]
);

    // sample handshake
    logic accept;

    // coarse bin of the incoming timestamp
    logic [hisPkg::BIN_BITS-1:0] sampleBin;

    // one valid per pixel, bin register shared by all
    logic [PIXEL_NUM-1:0]        updValid;
    logic [hisPkg::BIN_BITS-1:0] updBin;

    assign accept = sampleValid & sampleReady;

    // top BIN_BITS of the raw timestamp
    assign sampleBin = sample.data[hisPkg::DATA_BITS-1 -: hisPkg::BIN_BITS];

    always_ff @(posedge clk) begin
        if (reset) begin
            // closed until the clear sweep has run
            sampleReady <= 1'b0;
            updValid <= '0;
        end else begin
            // no samples while the banks are being read
            sampleReady <= ~busy;
            for (int i = 0; i < PIXEL_NUM; i++) begin
                // indexes at or above PIXEL_NUM match no bank and are lost
                updValid[i] <= accept && (sample.pixel == hisPkg::PIXEL_BITS'(i));
            end
        end
    end

    // payload, only meaningful with a valid
    always_ff @(posedge clk) begin
        if (accept) begin
            updBin <= sampleBin;
        end
    end

    // fan out to the banks
    always_comb begin
        for (int i = 0; i < PIXEL_NUM; i++) begin
            binUpdate[i].valid = updValid[i];
            binUpdate[i].bin = updBin;
        end
    end

endmodule

// ==== hisPkg.sv ====
package hisPkg;

    // raw timestamp width
    localparam int DATA_BITS = 10;

    // coarse bin index, top bits of the timestamp
    localparam int BIN_BITS = 4;
    localparam int BIN_NUM = 2 ** BIN_BITS;

    // per-bin hit counter, saturates at all ones
    localparam int COUNT_BITS = 8;

    // pixel index, up to 16 pixels
    localparam int PIXEL_BITS = 4;
    localparam int PIXEL_NUM_DEFAULT = 4;

    // one incoming hit
    typedef struct packed {
        logic [PIXEL_BITS-1:0] pixel;
        logic [DATA_BITS-1:0]  data;
    } hisSample_t;

    // routed hit, one per pixel bank
    typedef struct packed {
        logic                valid;
        logic [BIN_BITS-1:0] bin;
    } binUpdate_t;

    // peak of one pixel histogram
    typedef struct packed {
        logic [PIXEL_BITS-1:0] pixel;
        logic [BIN_BITS-1:0]   bin;
        logic [COUNT_BITS-1:0] count;
    } peakResult_t;

endpackage

// ==== hisTb.sv ====
`timescale 1ns/1ps

module hisTb;

    localparam int PIXEL_NUM = 4;
    localparam int COUNT_MAX = (1 << hisPkg::COUNT_BITS) - 1;
    localparam int STIM_LEN = 18;

    // one table row is a run of identical back-to-back hits
    typedef struct packed {
        logic [hisPkg::PIXEL_BITS-1:0] pixel;
        logic [hisPkg::DATA_BITS-1:0]  data;
        logic [15:0]                   reps;
        logic                          last;
    } stimEntry_t;

    // pixel, timestamp, hit count, acquisition end
    // bin is timestamp / 64
    localparam stimEntry_t STIM [STIM_LEN] = '{
        // acq 1 spreads hits with a tie on pixel 1 and pixel 2 untouched
        '{4'd0, 10'h0c5, 16'd5, 1'b0},
        '{4'd1, 10'h14a, 16'd4, 1'b0},
        '{4'd0, 10'h1c0, 16'd6, 1'b0},
        '{4'd5, 10'h07f, 16'd20, 1'b0},
        '{4'd3, 10'h3ff, 16'd3, 1'b0},
        '{4'd0, 10'h31e, 16'd2, 1'b0},
        '{4'd1, 10'h0b3, 16'd4, 1'b0},
        '{4'd0, 10'h1ea, 16'd3, 1'b0},
        '{4'd15, 10'h120, 16'd30, 1'b0},
        '{4'd1, 10'h26d, 16'd1, 1'b0},
        '{4'd3, 10'h001, 16'd1, 1'b1},
        // acq 2 saturates pixel 2 and alternates bins on pixel 3
        '{4'd2, 10'h2a9, 16'd300, 1'b0},
        '{4'd0, 10'h05c, 16'd3, 1'b0},
        '{4'd3, 10'h18d, 16'd1, 1'b0},
        '{4'd3, 10'h233, 16'd1, 1'b0},
        '{4'd3, 10'h1b0, 16'd1, 1'b0},
        '{4'd3, 10'h20f, 16'd1, 1'b1},
        // acq 3 is a single hit and the saturated bin must be gone
        '{4'd3, 10'h02a, 16'd1, 1'b1}
    };

    logic                clk;
    logic                reset;
    hisPkg::hisSample_t  sample;
    logic                sampleValid;
    logic                sampleReady;
    logic                acqDone;
    hisPkg::peakResult_t peak;
    logic                peakValid;
    logic                peakReady;
    logic                busy;

    // reference histograms and expected peaks in arrival order
    int                  model [PIXEL_NUM][hisPkg::BIN_NUM];
    hisPkg::peakResult_t expQ [$];
    int                  gotCount = 0;

    integer seed = 32'hf664;
    int     cycleCnt = 0;
    int     cycleLimit = 0;

    hisClkGen clkGen_i (
        .clk(clk),
        .reset(reset)
    );

    hisTop #(
        .PIXEL_NUM(PIXEL_NUM)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .sample(sample),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .acqDone(acqDone),
        .peak(peak),
        .peakValid(peakValid),
        .peakReady(peakReady),
        .busy(busy)
    );

    bind hisTop hisTb_chk chk_i (
        .clk(clk),
        .reset(reset),
        .sampleReady(sampleReady),
        .busy(busy),
        .peak(peak),
        .peakValid(peakValid),
        .peakReady(peakReady)
    );

    task automatic stopOnError(input string msg);
        $display("error: %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    // hits plus one full scan of every pixel per acquisition with 4x margin
    function automatic int stimCycles();
        int total;
        total = 0;
        for (int i = 0; i < STIM_LEN; i++) begin
            total += int'(STIM[i].reps);
            if (STIM[i].last) begin
                total += PIXEL_NUM * (hisPkg::BIN_NUM + 1);
            end
        end
        return 4 * total;
    endfunction

    // out of range pixels never reach a bank
    function automatic void addHit(input logic [hisPkg::PIXEL_BITS-1:0] pixel,
                                   input logic [hisPkg::DATA_BITS-1:0] data);
        int bin;
        bin = int'(data) / (1 << (hisPkg::DATA_BITS - hisPkg::BIN_BITS));
        if (int'(pixel) < PIXEL_NUM && model[pixel][bin] < COUNT_MAX) begin
            model[pixel][bin]++;
        end
    endfunction

    // highest count wins and a tie keeps the first bin
    function automatic void pushPeaks();
        hisPkg::peakResult_t res;
        int best;
        int bestBin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            best = 0;
            bestBin = 0;
            for (int b = 0; b < hisPkg::BIN_NUM; b++) begin
                if (model[p][b] > best) begin
                    best = model[p][b];
                    bestBin = b;
                end
                // read-and-clear empties the bank
                model[p][b] = 0;
            end
            res.pixel = hisPkg::PIXEL_BITS'(p);
            res.bin = hisPkg::BIN_BITS'(bestBin);
            res.count = hisPkg::COUNT_BITS'(best);
            expQ.push_back(res);
        end
    endfunction

    task automatic checkPeak(input hisPkg::peakResult_t got);
        hisPkg::peakResult_t exp;
        assert (gotCount < expQ.size())
            else stopOnError($sformatf("unexpected peak for pixel %0d", got.pixel));
        exp = expQ[gotCount];
        assert (got == exp)
            else stopOnError($sformatf(
                "peak %0d: pixel %0d bin %0d count %0d, expected %0d %0d %0d",
                gotCount, got.pixel, got.bin, got.count, exp.pixel, exp.bin, exp.count));
        gotCount++;
    endtask

    // close the acquisition and wait for all pixels to report
    task automatic endAcquisition();
        int target;
        sampleValid = 1'b0;
        acqDone = 1'b1;
        pushPeaks();
        target = expQ.size();
        @(negedge clk);
        acqDone = 1'b0;
        // busy from the edge after acqDone until the last peak is taken
        while (gotCount < target) begin
            assert (busy) else stopOnError("busy low while peaks were still pending");
            @(negedge clk);
        end
        @(negedge clk);
        assert (!busy) else stopOnError("busy still high after the last peak");
    endtask

    // random sink stalls
    // a transfer is logged ahead of its rising edge
    initial begin : peakSink
        integer rnd;
        peakReady = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                rnd = $random(seed);
                peakReady = rnd[0];
                if (peakValid && peakReady) begin
                    checkPeak(peak);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            $display("timeout: test did not finish within %0d cycles", cycleLimit);
            $display("Regression failed");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    initial begin : stimulus
        sample = '0;
        sampleValid = 1'b0;
        acqDone = 1'b0;
        cycleLimit = stimCycles();
        @(negedge clk);
        while (reset) @(negedge clk);
        // clear sweep keeps the port closed for a while
        while (!sampleReady) @(negedge clk);
        assert (!peakValid && !busy) else stopOnError("peakValid or busy high after reset");
        for (int i = 0; i < STIM_LEN; i++) begin
            for (int r = 0; r < int'(STIM[i].reps); r++) begin
                sample.pixel = STIM[i].pixel;
                sample.data = STIM[i].data;
                sampleValid = 1'b1;
                // held until the next rising edge takes it
                while (!sampleReady) @(negedge clk);
                addHit(STIM[i].pixel, STIM[i].data);
                @(negedge clk);
            end
            if (STIM[i].last) begin
                endAcquisition();
            end
        end
        // port reopens one edge after busy falls
        @(negedge clk);
        assert (sampleReady && !peakValid)
            else stopOnError("sample port closed or stray peak at the end");
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== hisTb_chk.sv ====
`timescale 1ns/1ps

module hisTb_chk (
    input logic                clk,
    input logic                reset,
    input logic                sampleReady,
    input logic                busy,
    input hisPkg::peakResult_t peak,
    input logic                peakValid,
    input logic                peakReady
);

    // offered peak waits unchanged for the sink
    peakHold: assert property (
        @(posedge clk) disable iff (reset)
        peakValid && !peakReady |=> peakValid && $stable(peak)
    ) else $error("peak changed or was withdrawn while peakReady was low");

    // sample port closed while the detector owns the banks
    inputClosed: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !sampleReady
    ) else $error("sampleReady was high while busy was high");

    // nothing on offer coming out of reset
    resetQuiet: assert property (
        @(posedge clk)
        reset |=> !peakValid
    ) else $error("peakValid was high in the cycle after reset");

endmodule

// ==== hisTop.sv ====
`timescale 1ns/1ps

module hisTop #(
    parameter int PIXEL_NUM = hisPkg::PIXEL_NUM_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    input  hisPkg::hisSample_t  sample,
    input  logic                sampleValid,
    output logic                sampleReady,
    input  logic                acqDone,
    output hisPkg::peakResult_t peak,
    output logic                peakValid,
    input  logic                peakReady,
    output logic                busy
);

    // distributor to banks
    hisPkg::binUpdate_t binUpdate [PIXEL_NUM];

    // bank read ports
    logic [hisPkg::COUNT_BITS-1:0] pixelCount [PIXEL_NUM];
    logic [PIXEL_NUM-1:0]          pixelReadEn;

    // detector scan side
    logic [hisPkg::BIN_BITS-1:0]   scanBin;
    logic [hisPkg::PIXEL_BITS-1:0] scanPixel;
    logic                          readEn;
    logic [hisPkg::COUNT_BITS-1:0] scanCount;

    // acqDone closes the sample port on the same edge busy rises
    logic inputHold;

    assign inputHold = busy | acqDone;

    hisDistributor #(
        .PIXEL_NUM(PIXEL_NUM)
    ) distributor_i (
        .clk(clk),
        .reset(reset),
        .sample(sample),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .busy(inputHold),
        .binUpdate(binUpdate)
    );

    // one histogram bank per pixel
    for (genvar g = 0; g < PIXEL_NUM; g++) begin : genBank
        // only the scanned bank is read, and cleared
        assign pixelReadEn[g] = readEn && (scanPixel == hisPkg::PIXEL_BITS'(g));

        hisBuilder builder_i (
            .clk(clk),
            .reset(reset),
            .binUpdate(binUpdate[g]),
            .readEn(pixelReadEn[g]),
            .readBin(scanBin),
            .count(pixelCount[g])
        );
    end

    // count select on the scanned pixel
    always_comb begin
        scanCount = '0;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (scanPixel == hisPkg::PIXEL_BITS'(p)) begin
                scanCount = pixelCount[p];
            end
        end
    end

    peakDetecter #(
        .PIXEL_NUM(PIXEL_NUM)
    ) detecter_i (
        .clk(clk),
        .reset(reset),
        .acqDone(acqDone),
        .scanBin(scanBin),
        .scanPixel(scanPixel),
        .readEn(readEn),
        .count(scanCount),
        .peak(peak),
        .peakValid(peakValid),
        .peakReady(peakReady),
        .busy(busy)
    );

endmodule

// ==== peakDetecter.sv ====
`timescale 1ns/1ps

module peakDetecter #(
    parameter int PIXEL_NUM = hisPkg::PIXEL_NUM_DEFAULT
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          acqDone,
    output logic [hisPkg::BIN_BITS-1:0]   scanBin,
    output logic [hisPkg::PIXEL_BITS-1:0] scanPixel,
    output logic                          readEn,
    input  logic [hisPkg::COUNT_BITS-1:0] count,
    output hisPkg::peakResult_t           peak,
    output logic                          peakValid,
    input  logic                          peakReady,
    output logic                          busy
);

    localparam int STEP_BITS = hisPkg::BIN_BITS + 1;

    // step counter limits for clear, drain and scan
    localparam logic [STEP_BITS-1:0] CLEAR_LAST = STEP_BITS'(hisPkg::BIN_NUM - 1);
    localparam logic [STEP_BITS-1:0] DRAIN_LAST = STEP_BITS'(1);
    localparam logic [STEP_BITS-1:0] SCAN_LAST = STEP_BITS'(hisPkg::BIN_NUM);
    localparam logic [hisPkg::PIXEL_BITS-1:0] LAST_PIXEL = hisPkg::PIXEL_BITS'(PIXEL_NUM - 1);

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        DRAIN,
        SCAN,
        OFFER
    } state_t;

    state_t state;
    logic [STEP_BITS-1:0] stepCnt;

    // count on the input belongs to cmpBin when cmpValid
    logic                        cmpValid;
    logic [hisPkg::BIN_BITS-1:0] cmpBin;

    // running maximum of the pixel being scanned
    logic [hisPkg::COUNT_BITS-1:0] maxCount;
    logic [hisPkg::BIN_BITS-1:0]   maxBin;
    logic [hisPkg::COUNT_BITS-1:0] nextMaxCount;
    logic [hisPkg::BIN_BITS-1:0]   nextMaxBin;

    logic scanLast;
    logic peakTaken;
    logic startScan;

    assign scanLast = (stepCnt == SCAN_LAST);
    assign peakTaken = (state == OFFER) && peakReady;

    // new pixel scan, out of the drain wait or after an accepted peak
    assign startScan = ((state == DRAIN) && (stepCnt == DRAIN_LAST)) ||
                       (peakTaken && (scanPixel != LAST_PIXEL));

    // one read per bin, the extra cycle only collects the last count
    assign readEn = (state == SCAN) && !scanLast;
    assign scanBin = stepCnt[hisPkg::BIN_BITS-1:0];

    assign busy = (state != IDLE);
    assign peakValid = (state == OFFER);

    // strict compare, so a tie keeps the lower bin
    always_comb begin
        nextMaxCount = maxCount;
        nextMaxBin = maxBin;
        if (cmpValid && (count > maxCount)) begin
            nextMaxCount = count;
            nextMaxBin = cmpBin;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // banks run their clear walk in step with CLEAR
            state <= CLEAR;
            stepCnt <= '0;
            scanPixel <= '0;
            cmpValid <= 1'b0;
        end else begin
            cmpValid <= readEn;
            case (state)
                IDLE: begin
                    if (acqDone) begin
                        state <= DRAIN;
                        stepCnt <= '0;
                        scanPixel <= '0;
                    end
                end
                CLEAR: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == CLEAR_LAST) begin
                        state <= IDLE;
                    end
                end
                // two cycles so the last updates reach memory
                DRAIN: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (startScan) begin
                        state <= SCAN;
                        stepCnt <= '0;
                    end
                end
                SCAN: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (scanLast) begin
                        state <= OFFER;
                    end
                end
                // held here until the peak is taken
                OFFER: begin
                    if (startScan) begin
                        state <= SCAN;
                        stepCnt <= '0;
                        scanPixel <= scanPixel + 1'b1;
                    end else if (peakTaken) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= scanBin;
        // empty histogram ends as bin 0, count 0
        if (startScan) begin
            maxCount <= '0;
            maxBin <= '0;
        end else begin
            maxCount <= nextMaxCount;
            maxBin <= nextMaxBin;
        end
        // last bin folded in on the same edge
        if ((state == SCAN) && scanLast) begin
            peak.pixel <= scanPixel;
            peak.bin <= nextMaxBin;
            peak.count <= nextMaxCount;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the histogram regression with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f compile.f --top-module hisTb -o hisSim \
    && ./obj_dir/hisSim > sim.log 2>&1 \
    || echo "build or simulation ended abnormally" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
